// ==== filelist.f ====
source/geom_pkg.sv
source/tri_stream_if.sv
source/triangle_assembler.sv
source/triangle_transform.sv
source/triangle_fifo.sv
source/triangle_setup.sv
source/geom_front_end.sv
verification/tb_clock_gen.sv
verification/geom_front_end_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module geom_front_end_tb \
    -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vgeom_front_end_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// ==== source/geom_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module geom_front_end import geom_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire             clk,
    input  wire             rstn,
    input  wire geom_word_u in_word,
    input  wire             in_is_xform,
    input  wire             in_last,
    input  wire             in_valid,
    output logic            in_ready,
    output triangle_t       out_triangle,
    output bbox_t           out_bbox,
    output logic            out_last,
    output logic            out_valid,
    input  wire             out_ready
);

    tri_stream_if #(.payload_t(triangle_tf_t)) tf_link ();     // Assembler to transform
    tri_stream_if #(.payload_t(triangle_t))    xf_link ();     // Transform to FIFO
    tri_stream_if #(.payload_t(triangle_t))    setup_link ();  // FIFO to setup

    triangle_assembler i_assembler (
        .clk         (clk),
        .rstn        (rstn),
        .in_word     (in_word),
        .in_is_xform (in_is_xform),
        .in_last     (in_last),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .tri_out     (tf_link.source)
    );

    triangle_transform i_transform (
        .clk     (clk),
        .rstn    (rstn),
        .tri_in  (tf_link.sink),
        .tri_out (xf_link.source)
    );

    triangle_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk  (clk),
        .rstn (rstn),
        .push (xf_link.sink),
        .pop  (setup_link.source)
    );

    triangle_setup i_setup (
        .clk          (clk),
        .rstn         (rstn),
        .tri_in       (setup_link.sink),
        .out_triangle (out_triangle),
        .out_bbox     (out_bbox),
        .out_last     (out_last),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

`default_nettype wire

// ==== source/geom_pkg.sv ====
`default_nettype none

package geom_pkg;

    typedef logic signed [15:0] fixed;  // Q8.8, wraps on overflow

    typedef struct packed {
        fixed x;
        fixed y;
        fixed z;
    } position_t;

    typedef struct packed {
        position_t   position;
        logic [15:0] color;  // RGB565
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        fixed m00, m01, m02;
        fixed m10, m11, m12;
        fixed m20, m21, m22;
    } rotmat_t;

    typedef struct packed {
        rotmat_t   rotmat;
        position_t position;  // Translation
    } transform_t;

    typedef struct packed {
        triangle_t  triangle;
        transform_t transform;
    } triangle_tf_t;

    // One matrix row plus the matching translation component
    typedef struct packed {
        fixed col0;
        fixed col1;
        fixed col2;
        fixed trans;
    } xform_row_t;

    typedef union packed {
        vertex_t    vertex;
        xform_row_t row;
    } geom_word_u;

    typedef struct packed {
        fixed x_min;
        fixed x_max;
        fixed y_min;
        fixed y_max;
    } bbox_t;

    // Full product, arithmetic shift by 8, low 16 bits kept
    function automatic fixed mul(fixed a, fixed b);
        logic signed [31:0] prod;
        prod = a * b;
        return prod[23:8];
    endfunction

    function automatic fixed add(fixed a, fixed b);
        return a + b;
    endfunction

    function automatic fixed min3(fixed a, fixed b, fixed c);
        fixed m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic fixed max3(fixed a, fixed b, fixed c);
        fixed m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

endpackage

`default_nettype wire

// ==== source/tri_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Valid/ready stream, data and last held from valid until transfer
interface tri_stream_if #(
    parameter type payload_t = logic
);

    payload_t data;
    logic     last;   // End of mesh
    logic     valid;
    logic     ready;

    modport source (output data, output last, output valid, input ready);
    modport sink   (input data, input last, input valid, output ready);

endinterface

`default_nettype wire

// ==== source/triangle_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module triangle_assembler import geom_pkg::*; (
    input  wire             clk,
    input  wire             rstn,
    input  wire geom_word_u in_word,
    input  wire             in_is_xform,
    input  wire             in_last,
    input  wire             in_valid,
    output logic            in_ready,
    tri_stream_if.source    tri_out
);

    logic [1:0] row_cnt;   // Next transform row, 0..2
    logic [1:0] slot_cnt;  // Next vertex slot, 0..2
    transform_t xform_r;
    logic       in_fire;

    // Stall the input while a finished triangle waits downstream
    assign in_ready = !tri_out.valid;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_cnt       <= 2'd0;
            slot_cnt      <= 2'd0;
            tri_out.valid <= 1'b0;
        end else begin
            if (tri_out.valid && tri_out.ready)
                tri_out.valid <= 1'b0;
            if (in_fire && in_is_xform)
                row_cnt <= (row_cnt == 2'd2) ? 2'd0 : row_cnt + 2'd1;
            if (in_fire && !in_is_xform) begin
                slot_cnt <= (slot_cnt == 2'd2) ? 2'd0 : slot_cnt + 2'd1;
                if (slot_cnt == 2'd2)
                    tri_out.valid <= 1'b1;  // Triangle complete
            end
        end
    end

    // Held transform, row r updates matrix row r and translation r
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            xform_r <= '0;
        end else if (in_fire && in_is_xform) begin
            case (row_cnt)
                2'd0: begin
                    xform_r.rotmat.m00 <= in_word.row.col0;
                    xform_r.rotmat.m01 <= in_word.row.col1;
                    xform_r.rotmat.m02 <= in_word.row.col2;
                    xform_r.position.x <= in_word.row.trans;
                end
                2'd1: begin
                    xform_r.rotmat.m10 <= in_word.row.col0;
                    xform_r.rotmat.m11 <= in_word.row.col1;
                    xform_r.rotmat.m12 <= in_word.row.col2;
                    xform_r.position.y <= in_word.row.trans;
                end
                default: begin
                    xform_r.rotmat.m20 <= in_word.row.col0;
                    xform_r.rotmat.m21 <= in_word.row.col1;
                    xform_r.rotmat.m22 <= in_word.row.col2;
                    xform_r.position.z <= in_word.row.trans;
                end
            endcase
        end
    end

    // Vertex slots fill straight into the outgoing payload
    always_ff @(posedge clk) begin
        if (in_fire && !in_is_xform) begin
            case (slot_cnt)
                2'd0: tri_out.data.triangle.v0 <= in_word.vertex;
                2'd1: tri_out.data.triangle.v1 <= in_word.vertex;
                default: begin
                    tri_out.data.triangle.v2 <= in_word.vertex;
                    tri_out.data.transform   <= xform_r;
                    tri_out.last             <= in_last;
                end
            endcase
        end
    end

    // Transform rows come as complete groups of three
    a_no_vertex_mid_xform: assert property (@(posedge clk) disable iff (!rstn)
        (in_fire && !in_is_xform) |-> (row_cnt == 2'd0));

endmodule

`default_nettype wire

// ==== source/triangle_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module triangle_fifo import geom_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  wire          clk,
    input  wire          rstn,
    tri_stream_if.sink   push,
    tri_stream_if.source pop
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    triangle_t mem_tri  [DEPTH];
    logic      mem_last [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;      // Entries in memory plus output register
    logic [CW-1:0] mem_count;
    logic          push_fire;
    logic          pop_fire;
    logic          load;       // Memory head moves into output register

    assign push.ready = (count != CW'(DEPTH));
    assign push_fire  = push.valid && push.ready;
    assign pop_fire   = pop.valid && pop.ready;
    assign mem_count  = count - CW'(pop.valid);
    assign load       = (mem_count != '0) && (!pop.valid || pop.ready);

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem_tri[wr_ptr]  <= push.data;
            mem_last[wr_ptr] <= push.last;
        end
        if (load) begin
            pop.data <= mem_tri[rd_ptr];  // Registered read
            pop.last <= mem_last[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop.valid <= 1'b0;
        end else begin
            if (push_fire)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (load)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(push_fire) - CW'(pop_fire);
            if (load)
                pop.valid <= 1'b1;
            else if (pop_fire)
                pop.valid <= 1'b0;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        count <= CW'(DEPTH));

    // A presented entry is always backed by the count
    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
        pop.valid |-> (count != '0));

endmodule

`default_nettype wire

// ==== source/triangle_setup.sv ====
`timescale 1ns/1ps
`default_nettype none

module triangle_setup import geom_pkg::*; (
    input  wire        clk,
    input  wire        rstn,
    tri_stream_if.sink tri_in,
    output triangle_t  out_triangle,
    output bbox_t      out_bbox,
    output logic       out_last,
    output logic       out_valid,
    input  wire        out_ready
);

    bbox_t box;

    // One-entry stage, refills in the same cycle it drains
    assign tri_in.ready = !out_valid || out_ready;

    always_comb begin
        box.x_min = min3(tri_in.data.v0.position.x, tri_in.data.v1.position.x,
                         tri_in.data.v2.position.x);
        box.x_max = max3(tri_in.data.v0.position.x, tri_in.data.v1.position.x,
                         tri_in.data.v2.position.x);
        box.y_min = min3(tri_in.data.v0.position.y, tri_in.data.v1.position.y,
                         tri_in.data.v2.position.y);
        box.y_max = max3(tri_in.data.v0.position.y, tri_in.data.v1.position.y,
                         tri_in.data.v2.position.y);
    end

    always_ff @(posedge clk) begin
        if (tri_in.valid && tri_in.ready) begin
            out_triangle <= tri_in.data;
            out_bbox     <= box;
            out_last     <= tri_in.last;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            out_valid <= 1'b0;
        else if (tri_in.valid && tri_in.ready)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;  // Drained with nothing behind
    end

endmodule

`default_nettype wire

// ==== source/triangle_transform.sv ====
`timescale 1ns/1ps
`default_nettype none

module triangle_transform import geom_pkg::*; (
    input  wire          clk,
    input  wire          rstn,
    tri_stream_if.sink   tri_in,
    tri_stream_if.source tri_out
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_MUL_V0 = 3'd1;
    localparam logic [2:0] S_ADD_V0 = 3'd2;
    localparam logic [2:0] S_MUL_V1 = 3'd3;
    localparam logic [2:0] S_ADD_V1 = 3'd4;
    localparam logic [2:0] S_MUL_V2 = 3'd5;
    localparam logic [2:0] S_ADD_V2 = 3'd6;
    localparam logic [2:0] S_OUT    = 3'd7;

    logic [2:0]  state;
    logic [2:0]  next_state;

    triangle_t   tri_r;
    rotmat_t     rot_r;
    position_t   pos_r;      // Translation

    vertex_t     act_vtx;    // Vertex being worked on
    fixed        prod   [3][3];
    fixed        prod_r [3][3];
    position_t   sum_pos;

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:   if (tri_in.valid) next_state = S_MUL_V0;
            S_MUL_V0: next_state = S_ADD_V0;
            S_ADD_V0: next_state = S_MUL_V1;
            S_MUL_V1: next_state = S_ADD_V1;
            S_ADD_V1: next_state = S_MUL_V2;
            S_MUL_V2: next_state = S_ADD_V2;
            S_ADD_V2: next_state = S_OUT;
            S_OUT:    if (tri_out.valid && tri_out.ready) next_state = S_IDLE;
            default:  next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    assign tri_in.ready = (state == S_IDLE);

    // Capture triangle, transform and mesh flag on accept
    always_ff @(posedge clk) begin
        if (tri_in.valid && tri_in.ready) begin
            tri_r        <= tri_in.data.triangle;
            rot_r        <= tri_in.data.transform.rotmat;
            pos_r        <= tri_in.data.transform.position;
            tri_out.last <= tri_in.last;
        end
    end

    always_comb begin
        case (state)
            S_MUL_V0, S_ADD_V0: act_vtx = tri_r.v0;
            S_MUL_V1, S_ADD_V1: act_vtx = tri_r.v1;
            S_MUL_V2, S_ADD_V2: act_vtx = tri_r.v2;
            default:            act_vtx = '0;
        endcase
    end

    // Nine shared multipliers, row i of the matrix against the vertex
    always_comb begin
        prod[0][0] = mul(rot_r.m00, act_vtx.position.x);
        prod[0][1] = mul(rot_r.m01, act_vtx.position.y);
        prod[0][2] = mul(rot_r.m02, act_vtx.position.z);
        prod[1][0] = mul(rot_r.m10, act_vtx.position.x);
        prod[1][1] = mul(rot_r.m11, act_vtx.position.y);
        prod[1][2] = mul(rot_r.m12, act_vtx.position.z);
        prod[2][0] = mul(rot_r.m20, act_vtx.position.x);
        prod[2][1] = mul(rot_r.m21, act_vtx.position.y);
        prod[2][2] = mul(rot_r.m22, act_vtx.position.z);
    end

    always_ff @(posedge clk) begin
        if (state == S_MUL_V0 || state == S_MUL_V1 || state == S_MUL_V2)
            prod_r <= prod;
    end

    // Pairwise sums with translation last
    always_comb begin
        sum_pos.x = add(add(prod_r[0][0], prod_r[0][1]), add(prod_r[0][2], pos_r.x));
        sum_pos.y = add(add(prod_r[1][0], prod_r[1][1]), add(prod_r[1][2], pos_r.y));
        sum_pos.z = add(add(prod_r[2][0], prod_r[2][1]), add(prod_r[2][2], pos_r.z));
    end

    always_ff @(posedge clk) begin
        case (state)
            S_ADD_V0: tri_out.data.v0 <= '{position: sum_pos, color: act_vtx.color};
            S_ADD_V1: tri_out.data.v1 <= '{position: sum_pos, color: act_vtx.color};
            S_ADD_V2: tri_out.data.v2 <= '{position: sum_pos, color: act_vtx.color};
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            tri_out.valid <= 1'b0;
        else if (state == S_ADD_V2)
            tri_out.valid <= 1'b1;
        else if (tri_out.valid && tri_out.ready)
            tri_out.valid <= 1'b0;
    end

    // Output held while the FIFO is full
    a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
        (tri_out.valid && !tri_out.ready) |=> $stable(tri_out.data));

endmodule

`default_nettype wire

// ==== verification/geom_front_end_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module geom_front_end_tb import geom_pkg::*; ();

    localparam int          DRIVE_DLY  = 10;
    localparam int          TOTAL_TRIS = 42;  // Sum over all tests
    localparam logic [31:0] SEED       = 32'he763_0b6c;

    typedef struct packed {
        triangle_t shape;
        bbox_t     box;
        logic      last;
    } expect_t;

    logic       clk;
    logic       rstn;
    geom_word_u in_word;
    logic       in_is_xform;
    logic       in_last;
    logic       in_valid;
    logic       in_ready;
    triangle_t  out_triangle;
    bbox_t      out_bbox;
    logic       out_last;
    logic       out_valid;
    logic       out_ready;

    expect_t     exp_q [$];
    expect_t     head;
    transform_t  cur_xform;       // Transform the assembler holds
    logic [31:0] stim_rng;
    logic [31:0] ready_rng;
    logic        stall_mode;
    logic        stalled;
    triangle_t   held_shape;
    int          err_count     = 0;
    int          sent_count    = 0;
    int          checked_count = 0;

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(2)) i_clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    geom_front_end #(.FIFO_DEPTH(4)) i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .in_word      (in_word),
        .in_is_xform  (in_is_xform),
        .in_last      (in_last),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_triangle (out_triangle),
        .out_bbox     (out_bbox),
        .out_last     (out_last),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    function automatic logic [191:0] random_bits192();
        logic [191:0] bits;
        for (int k = 0; k < 6; k++)
            bits[32*k +: 32] = next_stim();
        return bits;
    endfunction

    // Q8.8 product, full width then arithmetic shift
    function automatic fixed fx_mul(fixed a, fixed b);
        logic signed [31:0] p;
        p = 32'(a) * 32'(b);
        p = p >>> 8;
        return p[15:0];
    endfunction

    function automatic fixed fx_add(fixed a, fixed b);
        logic signed [16:0] s;
        s = a + b;
        return s[15:0];  // Wraps
    endfunction

    function automatic vertex_t transform_vertex(vertex_t v, transform_t xf);
        logic [143:0] rm;
        logic [47:0]  pos_in;
        logic [47:0]  pos_out;
        fixed         acc;
        vertex_t      res;
        rm     = xf.rotmat;
        pos_in = v.position;
        for (int i = 0; i < 3; i++) begin
            acc = '0;
            for (int j = 0; j < 3; j++)
                acc = fx_add(acc, fx_mul(rm[143 - 16*(3*i + j) -: 16], pos_in[47 - 16*j -: 16]));
            acc = fx_add(acc, xf.position[47 - 16*i -: 16]);  // Translation component i
            pos_out[47 - 16*i -: 16] = acc;
        end
        res.position = pos_out;
        res.color    = v.color;
        return res;
    endfunction

    function automatic triangle_t transform_triangle(triangle_t t, transform_t xf);
        triangle_t res;
        res.v0 = transform_vertex(t.v0, xf);
        res.v1 = transform_vertex(t.v1, xf);
        res.v2 = transform_vertex(t.v2, xf);
        return res;
    endfunction

    function automatic bbox_t bounding_box(triangle_t t);
        fixed  xs [3];
        fixed  ys [3];
        bbox_t b;
        xs[0] = t.v0.position.x;
        xs[1] = t.v1.position.x;
        xs[2] = t.v2.position.x;
        ys[0] = t.v0.position.y;
        ys[1] = t.v1.position.y;
        ys[2] = t.v2.position.y;
        b.x_min = xs[0];
        b.x_max = xs[0];
        b.y_min = ys[0];
        b.y_max = ys[0];
        for (int k = 1; k < 3; k++) begin
            if (xs[k] < b.x_min) b.x_min = xs[k];
            if (xs[k] > b.x_max) b.x_max = xs[k];
            if (ys[k] < b.y_min) b.y_min = ys[k];
            if (ys[k] > b.y_max) b.y_max = ys[k];
        end
        return b;
    endfunction

    task automatic check_value(input string what, input logic [191:0] got,
                               input logic [191:0] expected);
        if (got !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, expected);
            err_count++;
        end
    endtask

    task automatic wait_drive();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Holds the word until the assembler takes it
    task automatic send_word(input geom_word_u word, input logic is_xform, input logic last);
        in_word     = word;
        in_is_xform = is_xform;
        in_last     = last;
        in_valid    = 1'b1;
        while (!in_ready)
            wait_drive();
        wait_drive();
        in_valid = 1'b0;
    endtask

    task automatic load_transform(input transform_t t);
        geom_word_u   w;
        logic [143:0] rm;
        rm = t.rotmat;
        for (int r = 0; r < 3; r++) begin
            w.row.col0  = rm[143 - 48*r -: 16];
            w.row.col1  = rm[127 - 48*r -: 16];
            w.row.col2  = rm[111 - 48*r -: 16];
            w.row.trans = t.position[47 - 16*r -: 16];
            send_word(w, 1'b1, 1'b0);
        end
        cur_xform = t;
    endtask

    task automatic send_triangle(input triangle_t t, input logic [2:0] lasts,
                                 input logic unchanged);
        expect_t    e;
        geom_word_u w;
        e.shape = unchanged ? t : transform_triangle(t, cur_xform);
        e.box   = bounding_box(e.shape);
        e.last  = lasts[2];  // Only the third vertex counts
        w.vertex = t.v0;
        send_word(w, 1'b0, lasts[0]);
        w.vertex = t.v1;
        send_word(w, 1'b0, lasts[1]);
        w.vertex = t.v2;
        send_word(w, 1'b0, lasts[2]);
        exp_q.push_back(e);
        sent_count++;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            wait_drive();
        repeat (2) wait_drive();
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        $display("Test %0d (%s) done: %0d errors", num, name, err_count - err_start);
    endtask

    // Sparse random out_ready in stall mode, slower than the transform so the FIFO fills
    always begin
        @(posedge clk);
        #DRIVE_DLY;
        if (stall_mode) begin
            ready_rng = xorshift32(ready_rng);
            out_ready = (ready_rng[3:0] == 4'd0);
        end else begin
            out_ready = 1'b1;
        end
    end

    // Scoreboard and stall check, sampled mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (stalled) begin
                check_value("out_valid while stalled", 192'(out_valid), 192'(1'b1));
                check_value("out_triangle while stalled", 192'(out_triangle),
                            192'(held_shape));
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("At %0t a triangle came out that was never sent", $time);
                    err_count++;
                end else begin
                    head = exp_q.pop_front();
                    check_value("out_triangle", 192'(out_triangle), 192'(head.shape));
                    check_value("out_bbox", 192'(out_bbox), 192'(head.box));
                    check_value("out_last", 192'(out_last), 192'(head.last));
                    checked_count++;
                end
            end
            stalled    = out_valid && !out_ready;
            held_shape = out_triangle;
        end
    end

    initial begin
        repeat (TOTAL_TRIS * 40 + 200) @(posedge clk);
        $display("Watchdog expired: the pipeline hung, %0d of %0d triangles came out",
                 checked_count, sent_count);
        $display("Test failed");
        $finish;
    end

    initial begin
        int          err_start;
        transform_t  t;
        logic [31:0] r;
        in_word     = '0;
        in_is_xform = 1'b0;
        in_last     = 1'b0;
        in_valid    = 1'b0;
        out_ready   = 1'b1;
        stall_mode  = 1'b0;
        stalled     = 1'b0;
        held_shape  = '0;
        cur_xform   = '0;
        stim_rng    = SEED;
        ready_rng   = SEED;
        wait (rstn === 1'b1);
        wait_drive();

        err_start = err_count;
        check_value("out_valid after reset", 192'(out_valid), 192'(1'b0));
        check_value("in_ready after reset", 192'(in_ready), 192'(1'b1));
        report_test(1, "reset state", err_start);

        err_start = err_count;
        t = '0;
        t.rotmat.m00 = 16'sh0100;  // 1.0 on the diagonal
        t.rotmat.m11 = 16'sh0100;
        t.rotmat.m22 = 16'sh0100;
        load_transform(t);
        for (int k = 0; k < 4; k++)
            send_triangle(triangle_t'(random_bits192()), 3'b000, 1'b1);
        wait_drain();
        report_test(2, "identity transform", err_start);

        err_start = err_count;
        for (int n = 0; n < 3; n++) begin
            load_transform(transform_t'(random_bits192()));
            for (int k = 0; k < 4; k++)
                send_triangle(triangle_t'(random_bits192()), 3'b000, 1'b0);
        end
        wait_drain();
        report_test(3, "random transforms", err_start);

        // New rows follow right behind a triangle still in flight
        err_start = err_count;
        load_transform(transform_t'(random_bits192()));
        send_triangle(triangle_t'(random_bits192()), 3'b000, 1'b0);
        load_transform(transform_t'(random_bits192()));
        send_triangle(triangle_t'(random_bits192()), 3'b000, 1'b0);
        load_transform(transform_t'(random_bits192()));
        send_triangle(triangle_t'(random_bits192()), 3'b000, 1'b0);
        send_triangle(triangle_t'(random_bits192()), 3'b000, 1'b0);
        wait_drain();
        report_test(4, "transform change", err_start);

        err_start = err_count;
        stall_mode = 1'b1;
        for (int n = 0; n < 2; n++) begin
            load_transform(transform_t'(random_bits192()));
            for (int k = 0; k < 6; k++)
                send_triangle(triangle_t'(random_bits192()), 3'b000, 1'b0);
        end
        wait_drain();
        report_test(5, "back-pressure", err_start);

        // Noise on v0 and v1 must not leak into out_last
        err_start = err_count;
        load_transform(transform_t'(random_bits192()));
        for (int k = 0; k < 10; k++) begin
            r = next_stim();
            send_triangle(triangle_t'(random_bits192()), {(k % 3 == 0), r[1:0]}, 1'b0);
        end
        wait_drain();
        stall_mode = 1'b0;
        report_test(6, "end-of-mesh flag", err_start);

        $display("Checked %0d of %0d triangles, %0d errors", checked_count, sent_count,
                 err_count);
        if (err_count == 0 && checked_count == sent_count) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100,  // ns
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rstn = 1'b1;  // Released clear of the edge
    end

endmodule

`default_nettype wire
